// ==== filelist.f ====
+incdir+.
gfx_pkg.sv
fb_writer.sv
sram_dbuf_switch.sv
vga_fb_pixel_stream.sv
gfx_vga_dbuf.sv
tb_vga_checker.sv
tb_gfx_vga_dbuf.sv

// ==== Bender.yml ====
package:
  name: gfx_vga_dbuf

sources:
  - include_dirs:
      - .
    files:
      - gfx_pkg.sv
      - fb_writer.sv
      - sram_dbuf_switch.sv
      - vga_fb_pixel_stream.sv
      - gfx_vga_dbuf.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_vga_checker.sv
      - tb_gfx_vga_dbuf.sv

// ==== tb_gfx_vga_dbuf.sv ====
`default_nettype none

`include "gfx_config.svh"

module tb_gfx_vga_dbuf;
  import gfx_pkg::*;

  localparam int SEED         = 63;
  localparam int NUM_TESTS    = 6;
  localparam int CLK_PERIOD   = 4;
  localparam int FRAME_CLOCKS = `GFX_H_WHOLE * `GFX_V_WHOLE;
  localparam int TIMEOUT      = NUM_TESTS * 4 * FRAME_CLOCKS * CLK_PERIOD;
  localparam int PIX          = `GFX_PIXEL_BITS;
  localparam int FB_WORDS     = `GFX_H_VISIBLE * `GFX_V_VISIBLE;
  localparam int SRAM_WORDS   = 1 << `GFX_ADDR_BITS;
  localparam int STALL_LIMIT  = 4 * `GFX_SWITCH_HOLD;

  logic clk;
  logic reset;
  logic mem_switch;
  logic vga_enable;
  coord_x_t gfx_x;
  coord_y_t gfx_y;
  pixel_t gfx_color;
  logic gfx_valid;
  logic gfx_ready;
  logic gfx_vsync;
  logic [PIX/3-1:0] vga_red;
  logic [PIX/3-1:0] vga_grn;
  logic [PIX/3-1:0] vga_blu;
  logic vga_hsync;
  logic vga_vsync;
  logic front_sel;
  fb_addr_t sram0_addr;
  fb_addr_t sram1_addr;
  pixel_t sram0_wdata;
  pixel_t sram1_wdata;
  logic sram0_we;
  logic sram1_we;
  pixel_t sram0_rdata;
  pixel_t sram1_rdata;

  pixel_t sram0_mem [0:SRAM_WORDS-1];
  pixel_t sram1_mem [0:SRAM_WORDS-1];
  logic [FB_WORDS*PIX-1:0] ref_buf0;
  logic [FB_WORDS*PIX-1:0] ref_buf1;

  gfx_vga_dbuf u_dut (.*);

  tb_vga_checker u_checker (
    .clk (clk), .reset (reset), .vga_enable (vga_enable), .mem_switch (mem_switch),
    .gfx_ready (gfx_ready), .gfx_vsync (gfx_vsync), .front_sel (front_sel),
    .vga_red (vga_red), .vga_grn (vga_grn), .vga_blu (vga_blu),
    .vga_hsync (vga_hsync), .vga_vsync (vga_vsync),
    .ref_buf0 (ref_buf0), .ref_buf1 (ref_buf1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // synchronous srams, read data one clock after the address
  always @(posedge clk) begin
    if (sram0_we) begin
      sram0_mem[sram0_addr] <= sram0_wdata;
    end
    sram0_rdata <= sram0_mem[sram0_addr];
  end

  always @(posedge clk) begin
    if (sram1_we) begin
      sram1_mem[sram1_addr] <= sram1_wdata;
    end
    sram1_rdata <= sram1_mem[sram1_addr];
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("Done: errors found");
    $finish;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // offer one pixel, wait for acceptance, then mirror it into the back reference
  task automatic write_pixel(input int x, input int y, input pixel_t color, output int stall);
    logic in_range;
    int addr;
    in_range = (x < `GFX_H_VISIBLE) && (y < `GFX_V_VISIBLE);
    addr = y * `GFX_H_VISIBLE + x;
    gfx_x = coord_x_t'(x);
    gfx_y = coord_y_t'(y);
    gfx_color = color;
    gfx_valid = 1'b1;
    stall = 0;
    while (!gfx_ready && stall < STALL_LIMIT) begin
      @(negedge clk);
      stall++;
    end
    if (!gfx_ready) begin
      u_checker.report_failure("producer never saw gfx_ready come back");
    end else if (in_range && u_checker.exp_front) begin
      ref_buf0[addr*PIX +: PIX] = color;
    end else if (in_range) begin
      ref_buf1[addr*PIX +: PIX] = color;
    end
    @(negedge clk);
    gfx_valid = 1'b0;
    if (!in_range && (sram0_we || sram1_we)) begin
      u_checker.report_failure("off-screen pixel raised an sram write enable");
    end
  endtask

  task automatic write_random(input int count);
    int stall;
    repeat (count) begin
      write_pixel($urandom_range(`GFX_H_VISIBLE - 1, 0), $urandom_range(`GFX_V_VISIBLE - 1, 0),
                  pixel_t'($urandom_range((1 << PIX) - 1, 1)), stall);
    end
  endtask

  task automatic pulse_switch();
    mem_switch = 1'b1;
    @(negedge clk);
    mem_switch = 1'b0;
  endtask

  initial begin
    int stall;
    int a;
    void'($urandom(SEED));
    reset = 1'b1;
    mem_switch = 1'b0;
    vga_enable = 1'b1;
    gfx_x = '0;
    gfx_y = '0;
    gfx_color = '0;
    gfx_valid = 1'b0;
    sram0_rdata = '0;
    sram1_rdata = '0;
    ref_buf0 = '0;
    ref_buf1 = '0;
    for (a = 0; a < SRAM_WORDS; a++) begin
      sram0_mem[a] = '0;
      sram1_mem[a] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    wait_cycles(FRAME_CLOCKS);
    u_checker.end_test("reset_state");

    // back buffer fills while the front stays blank
    write_random(32);
    wait_cycles(FRAME_CLOCKS);
    u_checker.end_test("hidden_writes");

    // last pixel accepted on the same edge as the strobe
    mem_switch = 1'b1;
    write_pixel($urandom_range(`GFX_H_VISIBLE - 1, 0), $urandom_range(`GFX_V_VISIBLE - 1, 0),
                pixel_t'($urandom_range((1 << PIX) - 1, 1)), stall);
    mem_switch = 1'b0;
    wait_cycles(2 * FRAME_CLOCKS);
    u_checker.end_test("buffer_switch");

    pulse_switch();
    write_pixel(5, 7, pixel_t'($urandom_range((1 << PIX) - 1, 1)), stall);
    u_checker.check_value("stall_cycles", `GFX_SWITCH_HOLD, stall);
    wait_cycles(FRAME_CLOCKS);
    pulse_switch();
    wait_cycles(FRAME_CLOCKS + `GFX_SWITCH_HOLD);
    u_checker.end_test("stall_in_hold");

    repeat (16) begin
      write_pixel($urandom_range(`GFX_H_VISIBLE - 1, 0), $urandom_range(15, `GFX_V_VISIBLE),
                  pixel_t'($urandom_range((1 << PIX) - 1, 1)), stall);
    end
    wait_cycles(FRAME_CLOCKS);
    u_checker.end_test("off_screen");

    repeat (3) begin
      wait_cycles($urandom_range(200, 20));
      vga_enable = 1'b0;
      wait_cycles($urandom_range(60, 5));
      vga_enable = 1'b1;
    end
    wait_cycles(FRAME_CLOCKS);
    u_checker.end_test("raster_pause");

    u_checker.report_totals();
    if (u_checker.error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_vga_checker.sv ====
`default_nettype none

`include "gfx_config.svh"

module tb_vga_checker (
  input logic                                                    clk,
  input logic                                                    reset,
  input logic                                                    vga_enable,
  input logic                                                    mem_switch,
  input logic                                                    gfx_ready,
  input logic                                                    gfx_vsync,
  input logic                                                    front_sel,
  input logic [`GFX_PIXEL_BITS/3-1:0]                            vga_red,
  input logic [`GFX_PIXEL_BITS/3-1:0]                            vga_grn,
  input logic [`GFX_PIXEL_BITS/3-1:0]                            vga_blu,
  input logic                                                    vga_hsync,
  input logic                                                    vga_vsync,
  input logic [`GFX_H_VISIBLE*`GFX_V_VISIBLE*`GFX_PIXEL_BITS-1:0] ref_buf0,
  input logic [`GFX_H_VISIBLE*`GFX_V_VISIBLE*`GFX_PIXEL_BITS-1:0] ref_buf1
);
  import gfx_pkg::*;

  localparam int PIX      = `GFX_PIXEL_BITS;
  localparam int CHAN     = `GFX_PIXEL_BITS / 3;
  localparam int HS_START = `GFX_H_VISIBLE + `GFX_H_FRONT;
  localparam int VS_START = `GFX_V_VISIBLE + `GFX_V_FRONT;

  int error_count = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  // raster position and the two register stages behind it
  int     h_cnt;
  int     v_cnt;
  logic   en_q;
  pixel_t pix_q;
  logic   hs_q;
  logic   vs_q;
  pixel_t exp_color;
  logic   exp_hs;
  logic   exp_vs;

  // expected switch controller
  logic   exp_ready;
  logic   exp_front;
  logic   switch_q;
  int     hold_left;

  // color of a raster position from the front buffer reference
  function automatic pixel_t expected_pixel(input int h, input int v, input logic front);
    int idx;
    if (h >= `GFX_H_VISIBLE || v >= `GFX_V_VISIBLE) begin
      return '0;
    end
    idx = v * `GFX_H_VISIBLE + h;
    if (front) begin
      return ref_buf1[idx*PIX +: PIX];
    end
    return ref_buf0[idx*PIX +: PIX];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    error_count++;
    test_errors++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic report_totals();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      h_cnt = 0;
      v_cnt = 0;
      en_q = 1'b0;
      pix_q = '0;
      hs_q = 1'b0;
      vs_q = 1'b0;
      exp_color = '0;
      exp_hs = 1'b0;
      exp_vs = 1'b0;
      exp_ready = 1'b1;
      exp_front = 1'b0;
      switch_q = 1'b0;
      hold_left = 0;
    end else begin
      check_value("gfx_ready", exp_ready, gfx_ready);
      check_value("front_sel", exp_front, front_sel);
      check_value("vga_red", exp_color[3*CHAN-1:2*CHAN], vga_red);
      check_value("vga_grn", exp_color[2*CHAN-1:CHAN], vga_grn);
      check_value("vga_blu", exp_color[CHAN-1:0], vga_blu);
      check_value("vga_hsync", exp_hs, vga_hsync);
      check_value("vga_vsync", exp_vs, vga_vsync);
      check_value("gfx_vsync", exp_vs, gfx_vsync);

      // outputs load only after an enabled cycle
      if (en_q) begin
        exp_color = pix_q;
        exp_hs = hs_q;
        exp_vs = vs_q;
      end
      en_q = vga_enable;
      if (vga_enable) begin
        pix_q = expected_pixel(h_cnt, v_cnt, exp_front);
        hs_q = (h_cnt >= HS_START) && (h_cnt < HS_START + `GFX_H_SYNC);
        vs_q = (v_cnt >= VS_START) && (v_cnt < VS_START + `GFX_V_SYNC);
        h_cnt++;
        if (h_cnt == `GFX_H_WHOLE) begin
          h_cnt = 0;
          v_cnt = (v_cnt + 1) % `GFX_V_WHOLE;
        end
      end

      // strobe edges during the hold are ignored
      if (hold_left != 0) begin
        hold_left--;
        if (hold_left == 0) begin
          exp_ready = 1'b1;
          exp_front = !exp_front;
        end
      end else if (mem_switch && !switch_q) begin
        hold_left = `GFX_SWITCH_HOLD;
        exp_ready = 1'b0;
      end
      switch_q = mem_switch;
    end
  end

endmodule

`default_nettype wire

// ==== gfx_vga_dbuf.sv ====
`default_nettype none

`include "gfx_config.svh"

module gfx_vga_dbuf (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mem_switch,

  // producer
  input  gfx_pkg::coord_x_t            gfx_x,
  input  gfx_pkg::coord_y_t            gfx_y,
  input  gfx_pkg::pixel_t              gfx_color,
  input  logic                         gfx_valid,
  output logic                         gfx_ready,
  output logic                         gfx_vsync,

  // raster out
  input  logic                         vga_enable,
  output logic [`GFX_PIXEL_BITS/3-1:0] vga_red,
  output logic [`GFX_PIXEL_BITS/3-1:0] vga_grn,
  output logic [`GFX_PIXEL_BITS/3-1:0] vga_blu,
  output logic                         vga_hsync,
  output logic                         vga_vsync,
  output logic                         front_sel,

  // sram0 pins
  output gfx_pkg::fb_addr_t            sram0_addr,
  output gfx_pkg::pixel_t              sram0_wdata,
  output logic                         sram0_we,
  input  gfx_pkg::pixel_t              sram0_rdata,

  // sram1 pins
  output gfx_pkg::fb_addr_t            sram1_addr,
  output gfx_pkg::pixel_t              sram1_wdata,
  output logic                         sram1_we,
  input  gfx_pkg::pixel_t              sram1_rdata
);
  import gfx_pkg::*;

  logic     accept_en;
  logic     wr_en;
  fb_addr_t wr_addr;
  pixel_t   wr_data;
  fb_addr_t rd_addr;
  pixel_t   rd_data;

  fb_writer u_fb_writer (
    .clk       (clk),
    .reset     (reset),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .accept_en (accept_en),
    .gfx_ready (gfx_ready),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  sram_dbuf_switch u_sram_dbuf_switch (
    .clk         (clk),
    .reset       (reset),
    .mem_switch  (mem_switch),
    .accept_en   (accept_en),
    .front_sel   (front_sel),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .sram0_addr  (sram0_addr),
    .sram0_wdata (sram0_wdata),
    .sram0_we    (sram0_we),
    .sram0_rdata (sram0_rdata),
    .sram1_addr  (sram1_addr),
    .sram1_wdata (sram1_wdata),
    .sram1_we    (sram1_we),
    .sram1_rdata (sram1_rdata)
  );

  vga_fb_pixel_stream u_vga_fb_pixel_stream (
    .clk        (clk),
    .reset      (reset),
    .vga_enable (vga_enable),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  // producer can pace itself on the frame boundary
  assign gfx_vsync = vga_vsync;

endmodule

`default_nettype wire

// ==== vga_fb_pixel_stream.sv ====
`default_nettype none

`include "gfx_config.svh"

module vga_fb_pixel_stream (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           vga_enable,
  output gfx_pkg::fb_addr_t              rd_addr,
  input  gfx_pkg::pixel_t                rd_data,
  output logic [`GFX_PIXEL_BITS/3-1:0]   vga_red,
  output logic [`GFX_PIXEL_BITS/3-1:0]   vga_grn,
  output logic [`GFX_PIXEL_BITS/3-1:0]   vga_blu,
  output logic                           vga_hsync,
  output logic                           vga_vsync
);
  import gfx_pkg::*;

  localparam int CHAN_BITS = `GFX_PIXEL_BITS / 3;
  localparam int H_BITS    = $clog2(`GFX_H_WHOLE);
  localparam int V_BITS    = $clog2(`GFX_V_WHOLE);

  // sync windows
  localparam int HS_START = `GFX_H_VISIBLE + `GFX_H_FRONT;
  localparam int HS_END   = HS_START + `GFX_H_SYNC;
  localparam int VS_START = `GFX_V_VISIBLE + `GFX_V_FRONT;
  localparam int VS_END   = VS_START + `GFX_V_SYNC;

  logic [H_BITS-1:0] h_cnt;
  logic [V_BITS-1:0] v_cnt;
  logic              h_last;
  logic              visible;
  logic              hsync_c;
  logic              vsync_c;

  // first stage, position sampled while the sram read is in flight
  logic              en_q;
  logic              visible_q;
  logic              hsync_q;
  logic              vsync_q;

  assign h_last = (h_cnt == H_BITS'(`GFX_H_WHOLE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (vga_enable) begin
      if (h_last) begin
        h_cnt <= '0;
        if (v_cnt == V_BITS'(`GFX_V_WHOLE - 1)) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign visible = (h_cnt < `GFX_H_VISIBLE) && (v_cnt < `GFX_V_VISIBLE);
  assign hsync_c = (h_cnt >= HS_START) && (h_cnt < HS_END);
  assign vsync_c = (v_cnt >= VS_START) && (v_cnt < VS_END);

  // blanking positions just park the address at zero
  assign rd_addr = visible ? fb_addr_t'(v_cnt * `GFX_H_VISIBLE + h_cnt) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      en_q      <= 1'b0;
      visible_q <= 1'b0;
      hsync_q   <= 1'b0;
      vsync_q   <= 1'b0;
    end else begin
      en_q <= vga_enable;
      if (vga_enable) begin
        visible_q <= visible;
        hsync_q   <= hsync_c;
        vsync_q   <= vsync_c;
      end
    end
  end

  // second stage, only after an enabled cycle, so a pause holds the outputs
  always_ff @(posedge clk) begin
    if (reset) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b0;
      vga_vsync <= 1'b0;
    end else if (en_q) begin
      if (visible_q) begin
        vga_red <= rd_data[3*CHAN_BITS-1:2*CHAN_BITS];
        vga_grn <= rd_data[2*CHAN_BITS-1:CHAN_BITS];
        vga_blu <= rd_data[CHAN_BITS-1:0];
      end else begin
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end
      vga_hsync <= hsync_q;
      vga_vsync <= vsync_q;
    end
  end

endmodule

`default_nettype wire

// ==== sram_dbuf_switch.sv ====
`default_nettype none

`include "gfx_config.svh"

module sram_dbuf_switch (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_switch,
  output logic              accept_en,
  output logic              front_sel,

  // writer side
  input  logic              wr_en,
  input  gfx_pkg::fb_addr_t wr_addr,
  input  gfx_pkg::pixel_t   wr_data,

  // raster side
  input  gfx_pkg::fb_addr_t rd_addr,
  output gfx_pkg::pixel_t   rd_data,

  // sram0 pins
  output gfx_pkg::fb_addr_t sram0_addr,
  output gfx_pkg::pixel_t   sram0_wdata,
  output logic              sram0_we,
  input  gfx_pkg::pixel_t   sram0_rdata,

  // sram1 pins
  output gfx_pkg::fb_addr_t sram1_addr,
  output gfx_pkg::pixel_t   sram1_wdata,
  output logic              sram1_we,
  input  gfx_pkg::pixel_t   sram1_rdata
);
  import gfx_pkg::*;

  localparam int HOLD_BITS = $clog2(`GFX_SWITCH_HOLD + 1);

  buf_state_e           state;
  logic [HOLD_BITS-1:0] hold_cnt;
  logic                 switch_q;
  logic                 switch_rise;
  logic                 rd_sel_q;

  // rising edge of the switch strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      switch_q <= 1'b0;
    end else begin
      switch_q <= mem_switch;
    end
  end

  assign switch_rise = mem_switch && !switch_q;

  // edges seen during the hold are dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= BUF_RUN;
      hold_cnt  <= '0;
      front_sel <= 1'b0;
    end else begin
      case (state)
        BUF_RUN: begin
          if (switch_rise) begin
            state    <= BUF_HOLD;
            hold_cnt <= '0;
          end
        end
        BUF_HOLD: begin
          if (hold_cnt == HOLD_BITS'(`GFX_SWITCH_HOLD - 1)) begin
            // last pending write has landed, swap front and back
            state     <= BUF_RUN;
            front_sel <= !front_sel;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: state <= BUF_RUN;
      endcase
    end
  end

  assign accept_en = (state == BUF_RUN);

  // read data comes back a clock after the address, so follow the old select
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_sel_q <= 1'b0;
    end else begin
      rd_sel_q <= front_sel;
    end
  end

  // front_sel == 0 means sram0 is scanned and sram1 takes writes
  assign sram0_addr  = front_sel ? wr_addr : rd_addr;
  assign sram1_addr  = front_sel ? rd_addr : wr_addr;
  assign sram0_wdata = wr_data;
  assign sram1_wdata = wr_data;
  assign sram0_we    = wr_en && front_sel;
  assign sram1_we    = wr_en && !front_sel;

  assign rd_data = rd_sel_q ? sram1_rdata : sram0_rdata;

endmodule

`default_nettype wire

// ==== fb_writer.sv ====
`default_nettype none

`include "gfx_config.svh"

module fb_writer (
  input  logic              clk,
  input  logic              reset,
  input  gfx_pkg::coord_x_t gfx_x,
  input  gfx_pkg::coord_y_t gfx_y,
  input  gfx_pkg::pixel_t   gfx_color,
  input  logic              gfx_valid,
  input  logic              accept_en,
  output logic              gfx_ready,
  output logic              wr_en,
  output gfx_pkg::fb_addr_t wr_addr,
  output gfx_pkg::pixel_t   wr_data
);
  import gfx_pkg::*;

  logic     accept;
  logic     in_range;
  fb_addr_t lin_addr;

  // the switch controller decides when the producer may write
  assign gfx_ready = accept_en;
  assign accept    = gfx_valid && accept_en;

  // off-screen pixels are consumed but never written
  assign in_range = (gfx_x < `GFX_H_VISIBLE) && (gfx_y < `GFX_V_VISIBLE);

  // row major, one word per pixel
  assign lin_addr = fb_addr_t'(gfx_y * `GFX_H_VISIBLE + gfx_x);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en <= 1'b0;
    end else begin
      // single cycle strobe per accepted pixel
      wr_en <= accept && in_range;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr <= lin_addr;
      wr_data <= gfx_color;
    end
  end

endmodule

`default_nettype wire

// ==== gfx_pkg.sv ====
`default_nettype none

`include "gfx_config.svh"

package gfx_pkg;

  // packed color, red high, blue low
  typedef logic [`GFX_PIXEL_BITS-1:0] pixel_t;

  // sram word address
  typedef logic [`GFX_ADDR_BITS-1:0] fb_addr_t;

  // producer coordinates
  typedef logic [`GFX_X_BITS-1:0] coord_x_t;
  typedef logic [`GFX_Y_BITS-1:0] coord_y_t;

  // buffer switch controller
  typedef enum logic {
    BUF_RUN,
    BUF_HOLD
  } buf_state_e;

endpackage

`default_nettype wire

// ==== gfx_config.svh ====
`ifndef GFX_CONFIG_SVH
`define GFX_CONFIG_SVH

// horizontal raster, in clocks
`define GFX_H_VISIBLE 16
`define GFX_H_FRONT 2
`define GFX_H_SYNC 3
`define GFX_H_BACK 3
`define GFX_H_WHOLE 24

// vertical raster, in lines
`define GFX_V_VISIBLE 12
`define GFX_V_FRONT 1
`define GFX_V_SYNC 2
`define GFX_V_BACK 2
`define GFX_V_WHOLE 17

// 4 bits per channel, red in the top bits
`define GFX_PIXEL_BITS 12

// one word per visible pixel
`define GFX_ADDR_BITS 8

// producer coordinate widths
`define GFX_X_BITS 4
`define GFX_Y_BITS 4

// clocks of blocked writes after a switch strobe
`define GFX_SWITCH_HOLD 8

`endif
